/* verilog/pre_decode_settings.svh */
`ifndef PRE_DECODE_SETTINGS_SVH
`define PRE_DECODE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths

// data and pc width
`define IPD_XLEN 32

// register number width
`define IPD_REG_ADDR_W 5

//////////////////////////////////////////////////////////////////////
// buffering and flow control

// fetch buffer entries, also the upstream credits after reset
`define IPD_IN_DEPTH 4

// sender buffer entries
`define IPD_OUT_DEPTH 2

// downstream credits after reset
`define IPD_MAX_CREDITS 3

//////////////////////////////////////////////////////////////////////
// architectural constants

// link register written by bl
`define IPD_LINK_REG 1

`endif

/* verilog/pre_decode_pkg.sv */
`include "pre_decode_settings.svh"

package pre_decode_pkg;

    //////////////////////////////////////////////////////////////////////
    // instruction kinds

    // one code per supported instruction, invalid is zero
    typedef enum logic [5:0] {
        kind_invalid,
        // arithmetic and logic
        kind_add_w, kind_addi_w, kind_sub_w,
        kind_and, kind_andi, kind_or, kind_ori,
        kind_nor, kind_xor, kind_xori,
        // shifts
        kind_sll_w, kind_slli_w, kind_srl_w, kind_srli_w,
        kind_sra_w, kind_srai_w,
        // upper immediate
        kind_lu12i_w, kind_pcaddu12i,
        // set less than
        kind_slt, kind_slti, kind_sltu, kind_sltui,
        // branches and jumps
        kind_jirl, kind_b, kind_bl,
        kind_beq, kind_bne, kind_blt, kind_bge, kind_bltu, kind_bgeu,
        // memory
        kind_ld_b, kind_ld_h, kind_ld_w, kind_ld_bu, kind_ld_hu,
        kind_st_b, kind_st_h, kind_st_w
    } inst_kind_e;

    //////////////////////////////////////////////////////////////////////
    // execute and operand controls

    typedef enum logic [3:0] {
        alu_none,
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_nor, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_zero,
        src1_reg,
        src1_pc
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_zero,
        src2_reg,
        src2_imm,
        src2_four
    } src2_sel_e;

    //////////////////////////////////////////////////////////////////////
    // memory and write-back controls

    typedef enum logic [1:0] {
        width_word,
        width_half,
        width_byte
    } mem_width_e;

    typedef struct packed {
        logic       en;
        logic       write;
        // loads only, sign extension when low
        logic       zero_extend;
        mem_width_e width;
    } mem_ctrl_t;

    // stage where the result can first be forwarded
    typedef enum logic [1:0] {
        stage_none,
        stage_exe,
        stage_mem
    } result_stage_e;

    //////////////////////////////////////////////////////////////////////
    // link payloads

    typedef struct packed {
        logic [`IPD_XLEN-1:0] pc;
        logic [`IPD_XLEN-1:0] inst;
    } fetch_word_t;

    typedef struct packed {
        logic [`IPD_XLEN-1:0]       pc;
        inst_kind_e                 kind;
        logic [`IPD_REG_ADDR_W-1:0] rf_r_addr1;
        logic [`IPD_REG_ADDR_W-1:0] rf_r_addr2;
        logic [`IPD_REG_ADDR_W-1:0] rf_w_addr;
        logic                       rf_w_en;
        logic [`IPD_XLEN-1:0]       immediate;
        alu_op_e                    alu_op;
        src1_sel_e                  src1_sel;
        src2_sel_e                  src2_sel;
        mem_ctrl_t                  mem_ctrl;
        logic                       wb_from_mem;
        result_stage_e              result_stage;
    } decoded_t;

endpackage

/* verilog/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // requests past the limits are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // pointers wrap at DEPTH, not at a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

/* verilog/inst_classifier.sv */
`timescale 1ns/1ps
`include "pre_decode_settings.svh"

module inst_classifier (
    input  logic [`IPD_XLEN-1:0]     inst,
    output pre_decode_pkg::inst_kind_e kind
);

    import pre_decode_pkg::*;

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];

    // the four opcode spaces do not overlap for the kept set,
    // so at most one case below matches
    always_comb
    begin
        kind = kind_invalid;

        //////////////////////////////////////////////////////////////////
        // three-register and 5-bit shift forms
        case (op17)
            17'h00020: kind = kind_add_w;
            17'h00022: kind = kind_sub_w;
            17'h00024: kind = kind_slt;
            17'h00025: kind = kind_sltu;
            17'h00028: kind = kind_nor;
            17'h00029: kind = kind_and;
            17'h0002a: kind = kind_or;
            17'h0002b: kind = kind_xor;
            17'h0002e: kind = kind_sll_w;
            17'h0002f: kind = kind_srl_w;
            17'h00030: kind = kind_sra_w;
            17'h00081: kind = kind_slli_w;
            17'h00089: kind = kind_srli_w;
            17'h00091: kind = kind_srai_w;
            // mul, div and mod fall through to invalid
            default: ;
        endcase

        //////////////////////////////////////////////////////////////////
        // 12-bit immediate forms and memory access
        case (op10)
            10'h008: kind = kind_slti;
            10'h009: kind = kind_sltui;
            10'h00a: kind = kind_addi_w;
            10'h00d: kind = kind_andi;
            10'h00e: kind = kind_ori;
            10'h00f: kind = kind_xori;
            10'h0a0: kind = kind_ld_b;
            10'h0a1: kind = kind_ld_h;
            10'h0a2: kind = kind_ld_w;
            10'h0a4: kind = kind_st_b;
            10'h0a5: kind = kind_st_h;
            10'h0a6: kind = kind_st_w;
            10'h0a8: kind = kind_ld_bu;
            10'h0a9: kind = kind_ld_hu;
            default: ;
        endcase

        //////////////////////////////////////////////////////////////////
        // 20-bit upper immediate
        case (op7)
            7'h0a:   kind = kind_lu12i_w;
            7'h0e:   kind = kind_pcaddu12i;
            default: ;
        endcase

        //////////////////////////////////////////////////////////////////
        // branches and jumps
        case (op6)
            6'h13:   kind = kind_jirl;
            6'h14:   kind = kind_b;
            6'h15:   kind = kind_bl;
            6'h16:   kind = kind_beq;
            6'h17:   kind = kind_bne;
            6'h18:   kind = kind_blt;
            6'h19:   kind = kind_bge;
            6'h1a:   kind = kind_bltu;
            6'h1b:   kind = kind_bgeu;
            default: ;
        endcase
    end

endmodule

/* verilog/operand_decoder.sv */
`timescale 1ns/1ps
`include "pre_decode_settings.svh"

module operand_decoder (
    input  pre_decode_pkg::fetch_word_t word,
    input  pre_decode_pkg::inst_kind_e  kind,
    output pre_decode_pkg::decoded_t    decoded
);

    import pre_decode_pkg::*;

    // encoding format that picks fields and immediate layout
    typedef enum logic [3:0] {
        fmt_none, fmt_3r, fmt_si12, fmt_ui12, fmt_ui5, fmt_u20,
        fmt_jirl, fmt_br, fmt_b, fmt_bl, fmt_load, fmt_store
    } fmt_e;

    fmt_e                       fmt;
    alu_op_e                    alu;
    mem_width_e                 acc_width;
    src1_sel_e                  src1;
    src2_sel_e                  src2;
    logic [`IPD_XLEN-1:0]       inst;
    logic [`IPD_XLEN-1:0]       imm;
    logic [`IPD_REG_ADDR_W-1:0] rj;
    logic [`IPD_REG_ADDR_W-1:0] rk;
    logic [`IPD_REG_ADDR_W-1:0] rd;
    logic                       reads_rj;
    logic                       reads_rk;
    logic                       reads_rd;
    logic                       writes_rd;
    logic                       writes_link;
    logic                       is_load;
    logic                       is_store;

    assign inst = word.inst;
    assign rk   = inst[14:10];
    assign rj   = inst[9:5];
    assign rd   = inst[4:0];

    //////////////////////////////////////////////////////////////////////
    // kind to format, alu operation and access width

    always_comb
    begin
        case (kind)
            kind_add_w, kind_sub_w, kind_and, kind_or, kind_nor, kind_xor,
            kind_sll_w, kind_srl_w, kind_sra_w, kind_slt, kind_sltu:
                fmt = fmt_3r;
            kind_addi_w, kind_slti, kind_sltui:
                fmt = fmt_si12;
            kind_andi, kind_ori, kind_xori:
                fmt = fmt_ui12;
            kind_slli_w, kind_srli_w, kind_srai_w:
                fmt = fmt_ui5;
            kind_lu12i_w, kind_pcaddu12i:
                fmt = fmt_u20;
            kind_beq, kind_bne, kind_blt, kind_bge, kind_bltu, kind_bgeu:
                fmt = fmt_br;
            kind_ld_b, kind_ld_h, kind_ld_w, kind_ld_bu, kind_ld_hu:
                fmt = fmt_load;
            kind_st_b, kind_st_h, kind_st_w:
                fmt = fmt_store;
            kind_jirl: fmt = fmt_jirl;
            kind_b:    fmt = fmt_b;
            kind_bl:   fmt = fmt_bl;
            default:   fmt = fmt_none;
        endcase
    end

    always_comb
    begin
        case (kind)
            kind_sub_w:               alu = alu_sub;
            kind_slt, kind_slti:      alu = alu_slt;
            kind_sltu, kind_sltui:    alu = alu_sltu;
            kind_and, kind_andi:      alu = alu_and;
            kind_or, kind_ori:        alu = alu_or;
            kind_nor:                 alu = alu_nor;
            kind_xor, kind_xori:      alu = alu_xor;
            kind_sll_w, kind_slli_w:  alu = alu_sll;
            kind_srl_w, kind_srli_w:  alu = alu_srl;
            kind_sra_w, kind_srai_w:  alu = alu_sra;
            kind_lu12i_w:             alu = alu_lui;
            // address and link arithmetic
            kind_add_w, kind_addi_w, kind_jirl, kind_bl, kind_pcaddu12i:
                alu = alu_add;
            default:
                alu = (fmt == fmt_load || fmt == fmt_store) ? alu_add : alu_none;
        endcase
    end

    always_comb
    begin
        case (kind)
            kind_ld_h, kind_ld_hu, kind_st_h: acc_width = width_half;
            kind_ld_b, kind_ld_bu, kind_st_b: acc_width = width_byte;
            default:                          acc_width = width_word;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // register usage

    assign is_load     = (fmt == fmt_load);
    assign is_store    = (fmt == fmt_store);
    assign reads_rj    = fmt inside {fmt_3r, fmt_si12, fmt_ui12, fmt_ui5,
                                     fmt_jirl, fmt_br, fmt_load, fmt_store};
    assign reads_rk    = (fmt == fmt_3r);
    // branches compare rj with rd and stores take their data from rd
    assign reads_rd    = fmt inside {fmt_br, fmt_store};
    assign writes_rd   = fmt inside {fmt_3r, fmt_si12, fmt_ui12, fmt_ui5,
                                     fmt_u20, fmt_jirl, fmt_load};
    assign writes_link = (fmt == fmt_bl);

    //////////////////////////////////////////////////////////////////////
    // immediate and operand sources

    always_comb
    begin
        case (fmt)
            fmt_si12, fmt_load, fmt_store:
                imm = `IPD_XLEN'($signed(inst[21:10]));
            fmt_ui12: imm = `IPD_XLEN'(inst[21:10]);
            fmt_ui5:  imm = `IPD_XLEN'(inst[14:10]);
            fmt_u20:  imm = `IPD_XLEN'({inst[24:5], 12'h000});
            fmt_jirl, fmt_br:
                imm = `IPD_XLEN'($signed({inst[25:10], 2'b00}));
            // offs26 is split with its high part in the low bits
            fmt_b, fmt_bl:
                imm = `IPD_XLEN'($signed({inst[9:0], inst[25:10], 2'b00}));
            default:  imm = '0;
        endcase
    end

    always_comb
    begin
        if (kind == kind_pcaddu12i || writes_link)
            src1 = src1_pc;
        else if (reads_rj)
            src1 = src1_reg;
        else
            src1 = src1_zero;
    end

    always_comb
    begin
        case (fmt)
            fmt_3r, fmt_br:   src2 = src2_reg;
            fmt_bl:           src2 = src2_four;
            fmt_si12, fmt_ui12, fmt_ui5, fmt_u20, fmt_jirl, fmt_load, fmt_store:
                src2 = src2_imm;
            default:          src2 = src2_zero;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // record assembly

    always_comb
    begin
        decoded.pc         = word.pc;
        decoded.kind       = kind;
        decoded.rf_r_addr1 = reads_rj ? rj : '0;
        decoded.rf_r_addr2 = reads_rk ? rk : (reads_rd ? rd : '0);
        if (writes_rd)
            decoded.rf_w_addr = rd;
        else if (writes_link)
            decoded.rf_w_addr = `IPD_REG_ADDR_W'(`IPD_LINK_REG);
        else
            decoded.rf_w_addr = '0;
        decoded.rf_w_en              = writes_rd || writes_link;
        decoded.immediate            = imm;
        decoded.alu_op               = alu;
        decoded.src1_sel             = src1;
        decoded.src2_sel             = src2;
        decoded.mem_ctrl.en          = is_load || is_store;
        decoded.mem_ctrl.write       = is_store;
        decoded.mem_ctrl.zero_extend = (kind == kind_ld_bu) || (kind == kind_ld_hu);
        decoded.mem_ctrl.width       = acc_width;
        decoded.wb_from_mem          = is_load;
        if (is_load)
            decoded.result_stage = stage_mem;
        else if (writes_rd || writes_link)
            decoded.result_stage = stage_exe;
        else
            decoded.result_stage = stage_none;
    end

endmodule

/* verilog/decode_sender.sv */
`timescale 1ns/1ps
`include "pre_decode_settings.svh"

module decode_sender (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  pre_decode_pkg::decoded_t push_data,
    output logic                     space,
    output logic                     id_valid,
    output pre_decode_pkg::decoded_t id_data,
    input  logic                     id_credit
);

    import pre_decode_pkg::*;

    localparam int CREDIT_W = $clog2(`IPD_MAX_CREDITS + 1);

    logic                empty;
    logic                full;
    logic [CREDIT_W-1:0] credits;

    //////////////////////////////////////////////////////////////////////
    // output buffer

    credit_fifo #(
        .payload_t (decoded_t),
        .DEPTH     (`IPD_OUT_DEPTH)
    ) out_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (id_valid),
        .head      (id_data),
        .empty     (empty),
        .full      (full)
    );

    assign space = !full;

    // head leaves as soon as a credit is held
    assign id_valid = !empty && (credits != '0);

    //////////////////////////////////////////////////////////////////////
    // downstream credit counter

    always_ff @(posedge clk)
    begin
        if (reset)
            credits <= CREDIT_W'(`IPD_MAX_CREDITS);
        else
        begin
            case ({id_valid, id_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                // send and return in one cycle cancel
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* verilog/pre_decode_stage.sv */
`timescale 1ns/1ps
`include "pre_decode_settings.svh"

module pre_decode_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        fetch_valid,
    input  pre_decode_pkg::fetch_word_t fetch_data,
    output logic                        fetch_credit,
    output logic                        id_valid,
    output pre_decode_pkg::decoded_t    id_data,
    input  logic                        id_credit
);

    import pre_decode_pkg::*;

    fetch_word_t fetch_head;
    logic        fetch_empty;
    logic        sender_space;
    logic        pop;
    inst_kind_e  head_kind;
    decoded_t    head_decoded;

    //////////////////////////////////////////////////////////////////////
    // input side

    // upstream spends a credit per word, so the buffer never overflows
    credit_fifo #(
        .payload_t (fetch_word_t),
        .DEPTH     (`IPD_IN_DEPTH)
    ) fetch_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (fetch_valid),
        .push_data (fetch_data),
        .pop       (pop),
        .head      (fetch_head),
        .empty     (fetch_empty),
        .full      ()
    );

    // each pop frees one entry, returned upstream as a credit
    assign pop          = !fetch_empty && sender_space;
    assign fetch_credit = pop;

    //////////////////////////////////////////////////////////////////////
    // decode of the buffer head

    inst_classifier classifier (
        .inst (fetch_head.inst),
        .kind (head_kind)
    );

    operand_decoder decoder (
        .word    (fetch_head),
        .kind    (head_kind),
        .decoded (head_decoded)
    );

    //////////////////////////////////////////////////////////////////////
    // output side

    decode_sender sender (
        .clk       (clk),
        .reset     (reset),
        .push      (pop),
        .push_data (head_decoded),
        .space     (sender_space),
        .id_valid  (id_valid),
        .id_data   (id_data),
        .id_credit (id_credit)
    );

endmodule

/* bench/pre_decode_tb.sv */
`timescale 1ns/1ps
`include "pre_decode_settings.svh"

module pre_decode_tb;

    import pre_decode_pkg::*;

    localparam int N_PAT    = 43;
    localparam int N_FIELDS = 14;

    logic        clk;
    logic        reset;
    logic        fetch_valid;
    fetch_word_t fetch_data;
    logic        fetch_credit;
    logic        id_valid;
    decoded_t    id_data;
    logic        id_credit;

    logic [31:0] pat_mem [N_PAT*N_FIELDS];

    int sent_words;
    int fetch_returned;
    int received;

    pre_decode_stage dut0 (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .fetch_credit (fetch_credit),
        .id_valid     (id_valid),
        .id_data      (id_data),
        .id_credit    (id_credit)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift(inout logic [31:0] state);
        state = state ^ (state << 13);
        state = state ^ (state >> 17);
        state = state ^ (state << 5);
        return state;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            report_failure($sformatf("FAIL %s: got %h, expected %h", name, actual, expected));
    endtask

    task automatic check_record(input int idx);
        int b;
        b = idx * N_FIELDS;
        check_value("id_data.pc", id_data.pc, pat_mem[b]);
        check_value("id_data.kind", 32'(id_data.kind), pat_mem[b+2]);
        check_value("id_data.rf_r_addr1", 32'(id_data.rf_r_addr1), pat_mem[b+3]);
        check_value("id_data.rf_r_addr2", 32'(id_data.rf_r_addr2), pat_mem[b+4]);
        check_value("id_data.rf_w_addr", 32'(id_data.rf_w_addr), pat_mem[b+5]);
        check_value("id_data.rf_w_en", 32'(id_data.rf_w_en), pat_mem[b+6]);
        check_value("id_data.immediate", id_data.immediate, pat_mem[b+7]);
        check_value("id_data.alu_op", 32'(id_data.alu_op), pat_mem[b+8]);
        check_value("id_data.src1_sel", 32'(id_data.src1_sel), pat_mem[b+9]);
        check_value("id_data.src2_sel", 32'(id_data.src2_sel), pat_mem[b+10]);
        check_value("id_data.mem_ctrl", 32'(id_data.mem_ctrl), pat_mem[b+11]);
        check_value("id_data.wb_from_mem", 32'(id_data.wb_from_mem), pat_mem[b+12]);
        check_value("id_data.result_stage", 32'(id_data.result_stage), pat_mem[b+13]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, reset and pattern load

    initial
    begin
        clk        = 1'b0;
        reset      = 1'b1;
        sent_words = 0;
        $readmemh("bench/pre_decode_patterns.txt", pat_mem);
        if ($isunknown(pat_mem[N_PAT*N_FIELDS-1]))
            report_failure("pattern file is missing or shorter than expected");
        repeat (8) @(negedge clk);
        reset = 1'b0;
    end

    // watchdog
    initial
    begin
        repeat (8 + N_PAT * 40) @(posedge clk);
        $display("timeout: not all decoded records arrived in time");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    // fetch credits counted where the pop takes place
    initial
        fetch_returned = 0;

    always @(posedge clk)
    begin
        if (!reset && fetch_credit)
        begin
            if (fetch_returned >= sent_words)
                report_failure("fetch credit returned with no word outstanding");
            fetch_returned <= fetch_returned + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fetch side driver

    initial
    begin : drive_fetch
        logic [31:0] rng;
        int          gap;
        rng         = 32'd19814;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        wait (reset == 1'b0);
        // idle after reset, nothing may come out
        repeat (3)
        begin
            @(negedge clk);
            check_value("id_valid", 32'(id_valid), 32'd0);
            check_value("fetch_credit", 32'(fetch_credit), 32'd0);
        end
        for (int i = 0; i < N_PAT; i++)
        begin
            @(negedge clk);
            fetch_valid = 1'b0;
            gap = ((xorshift(rng) % 4) == 0) ? int'(xorshift(rng) % 4) : 0;
            repeat (gap) @(negedge clk);
            // only send while a credit is held
            while (sent_words - fetch_returned >= `IPD_IN_DEPTH)
                @(negedge clk);
            fetch_valid     = 1'b1;
            fetch_data.pc   = pat_mem[i*N_FIELDS];
            fetch_data.inst = pat_mem[i*N_FIELDS+1];
            sent_words      = sent_words + 1;
        end
        @(negedge clk);
        fetch_valid = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // decode side consumer

    initial
    begin : consume_records
        logic [31:0] rng;
        int          cycle;
        int          returned;
        int          sent_ids;
        int          due [$];
        rng       = 32'd19814;
        cycle     = 0;
        returned  = 0;
        sent_ids  = 0;
        received  = 0;
        id_credit = 1'b0;
        // move away from the driver's sequence
        repeat (7) void'(xorshift(rng));
        wait (reset == 1'b0);
        while (received < N_PAT || due.size() > 0)
        begin
            @(negedge clk);
            cycle = cycle + 1;
            if (id_valid)
            begin
                if (sent_ids + 1 > `IPD_MAX_CREDITS + returned)
                    report_failure("id_valid asserted without a downstream credit");
                if (received >= N_PAT)
                    report_failure("more decoded records than pattern lines");
                check_record(received);
                received = received + 1;
                sent_ids = sent_ids + 1;
                due.push_back(cycle + int'(xorshift(rng) % 6));
            end
            // one credit pulse per cycle, oldest first
            id_credit = 1'b0;
            if (due.size() > 0 && due[0] <= cycle)
            begin
                void'(due.pop_front());
                id_credit = 1'b1;
                returned  = returned + 1;
            end
        end
        @(negedge clk);
        id_credit = 1'b0;
        repeat (4) @(negedge clk);
        check_value("id_valid", 32'(id_valid), 32'd0);
        check_value("fetch_credit count", 32'(fetch_returned), 32'(N_PAT));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* pre_decode.f */
+incdir+verilog
verilog/pre_decode_pkg.sv
verilog/credit_fifo.sv
verilog/inst_classifier.sv
verilog/operand_decoder.sv
verilog/decode_sender.sv
verilog/pre_decode_stage.sv
bench/pre_decode_tb.sv

/* bench/pre_decode_patterns.txt */
// pc inst kind rf_r_addr1 rf_r_addr2 rf_w_addr rf_w_en immediate
// alu_op src1_sel src2_sel mem_ctrl wb_from_mem result_stage
1c000000 00101483 01 04 05 03 1 00000000 1 1 1 00 0 1
1c000004 00111483 03 04 05 03 1 00000000 2 1 1 00 0 1
1c000008 00121483 13 04 05 03 1 00000000 3 1 1 00 0 1
1c00000c 00129483 15 04 05 03 1 00000000 4 1 1 00 0 1
1c000010 00141483 08 04 05 03 1 00000000 7 1 1 00 0 1
1c000014 00149483 04 04 05 03 1 00000000 5 1 1 00 0 1
1c000018 00151483 06 04 05 03 1 00000000 6 1 1 00 0 1
1c00001c 00159483 09 04 05 03 1 00000000 8 1 1 00 0 1
1c000020 00171483 0b 04 05 03 1 00000000 9 1 1 00 0 1
1c000024 00179483 0d 04 05 03 1 00000000 a 1 1 00 0 1
1c000028 00181483 0f 04 05 03 1 00000000 b 1 1 00 0 1
1c00002c 00409c83 0c 04 00 03 1 00000007 9 1 2 00 0 1
1c000030 00449c83 0e 04 00 03 1 00000007 a 1 2 00 0 1
1c000034 0048fc83 10 04 00 03 1 0000001f b 1 2 00 0 1
1c000038 02bffc83 02 04 00 03 1 ffffffff 1 1 2 00 0 1
1c00003c 02200083 14 04 00 03 1 fffff800 3 1 2 00 0 1
1c000040 02448c83 16 04 00 03 1 00000123 4 1 2 00 0 1
1c000044 037ffc83 05 04 00 03 1 00000fff 5 1 2 00 0 1
1c000048 03a00083 07 04 00 03 1 00000800 6 1 2 00 0 1
1c00004c 03c2ac83 0a 04 00 03 1 000000ab 8 1 2 00 0 1
1c000050 142468a3 11 00 00 03 1 12345000 c 0 2 00 0 1
1c000054 1d000003 12 00 00 03 1 80000000 1 2 2 00 0 1
1c000058 4ffffc83 17 04 00 03 1 fffffffc 1 1 2 00 0 1
1c00005c 50004000 18 00 00 00 0 00000040 0 0 0 00 0 0
1c000060 57ffffff 19 00 00 01 1 fffffffc 1 2 3 00 0 1
1c000064 58002083 1a 04 03 00 0 00000020 0 1 1 00 0 0
1c000068 5c002083 1b 04 03 00 0 00000020 0 1 1 00 0 0
1c00006c 60002083 1c 04 03 00 0 00000020 0 1 1 00 0 0
1c000070 66000083 1d 04 03 00 0 fffe0000 0 1 1 00 0 0
1c000074 68002083 1e 04 03 00 0 00000020 0 1 1 00 0 0
1c000078 6c002083 1f 04 03 00 0 00000020 0 1 1 00 0 0
1c00007c 28004083 20 04 00 03 1 00000010 1 1 2 12 1 2
1c000080 28404083 21 04 00 03 1 00000010 1 1 2 11 1 2
1c000084 28bff083 22 04 00 03 1 fffffffc 1 1 2 10 1 2
1c000088 2a004083 23 04 00 03 1 00000010 1 1 2 16 1 2
1c00008c 2a404083 24 04 00 03 1 00000010 1 1 2 15 1 2
1c000090 29004083 25 04 03 00 0 00000010 1 1 2 1a 0 0
1c000094 29404083 26 04 03 00 0 00000010 1 1 2 19 0 0
1c000098 29804083 27 04 03 00 0 00000010 1 1 2 18 0 0
1c00009c 001c1483 00 00 00 00 0 00000000 0 0 0 00 0 0
1c0000a0 00201483 00 00 00 00 0 00000000 0 0 0 00 0 0
1c0000a4 ffffffff 00 00 00 00 0 00000000 0 0 0 00 0 0
1c0000a8 00000000 00 00 00 00 0 00000000 0 0 0 00 0 0
